// File: Bender.yml
package:
  name: l2_cache

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/l2_cache_pkg.sv
      - hdl/l2_req_decode.sv
      - hdl/l2_way.sv
      - hdl/l2_way_select.sv
      - hdl/l2_cache_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - verif/tb_clk_gen.sv
      - verif/l2_cache_properties.sv
      - verif/tb_l2_cache_top.sv

// File: hdl/l2_cache_pkg.sv
package l2_cache_pkg;

    `include "l2_cache_settings.svh"

    // Derived widths
    localparam int unsigned L2_INDEX_W = $clog2(`L2_NUM_SETS);     // 8 bits of set index
    localparam int unsigned L2_TAG_W   = `L2_ADDR_W - L2_INDEX_W;   // 22 high + 2 low bits
    localparam int unsigned L2_AGE_W   = $clog2(`L2_NUM_WAYS);      // Saturates at ways - 1

    // Access size decoded from the byte enable
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,   // 0001
        SIZE_HALF = 2'd1,   // 0011
        SIZE_WORD = 2'd2    // 1111
    } l2_size_e;

    // Decoded access, broadcast to every way and to the selector
    typedef struct packed {
        logic                      valid;   // Strobe with a legal byte enable
        logic                      write;
        l2_size_e                  size;
        logic [L2_INDEX_W-1:0]     index;
        logic [L2_TAG_W-1:0]       tag;
        logic [`L2_DATA_W-1:0]     wdata;
        logic [`L2_DATA_W-1:0]     fill;    // Word from L3 for the same address
    } l2_req_t;

    // Lookup result of one way for the indexed set
    typedef struct packed {
        logic                      hit;     // Valid line with matching tag
        logic                      valid;   // Line valid regardless of tag
        logic [`L2_DATA_W-1:0]     data;
    } l2_way_rd_t;

    // Line write into one way
    typedef struct packed {
        logic                      en;
        logic [L2_INDEX_W-1:0]     index;
        logic [L2_TAG_W-1:0]       tag;
        logic [`L2_DATA_W-1:0]     data;
    } l2_way_wr_t;

    // Registered response to the core
    typedef struct packed {
        logic                      valid;
        logic                      hit;
        logic                      err;     // Illegal byte enable
        logic [`L2_DATA_W-1:0]     data;    // Zero-extended to the access size
    } l2_rsp_t;

endpackage

// File: hdl/l2_cache_settings.svh
`ifndef L2_CACHE_SETTINGS_SVH
`define L2_CACHE_SETTINGS_SVH

// Core interface widths
`define L2_ADDR_W    32     // Byte address from the core
`define L2_DATA_W    32     // One word per line

// Cache geometry, 4 KB of data in total
`define L2_NUM_SETS  256    // Lines per way
`define L2_NUM_WAYS  4      // Default associativity

// Address bits 1..0 stay in the tag, so the index starts above them
`define L2_LOW_TAG_W 2

`endif

// File: hdl/l2_cache_top.sv
`timescale 1ns/1ps

`include "l2_cache_settings.svh"

module l2_cache_top #(
    parameter int NUM_WAYS = `L2_NUM_WAYS
) (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  logic                  acc_valid_i,  // One access per strobe cycle
    input  logic                  wr_en_i,
    input  logic [`L2_ADDR_W-1:0] addr_i,
    input  logic [`L2_DATA_W-1:0] wr_data_i,
    input  logic [3:0]            byte_en_i,
    input  logic [`L2_DATA_W-1:0] l3_data_i,    // Next-level word for addr_i
    output logic                  rsp_valid_o,
    output logic                  rsp_hit_o,
    output logic                  rsp_err_o,
    output logic [`L2_DATA_W-1:0] rsp_data_o
);

    l2_cache_pkg::l2_req_t                    req;
    logic                                     req_err;
    l2_cache_pkg::l2_way_rd_t [NUM_WAYS-1:0]  way_rd;   // Lookup results
    l2_cache_pkg::l2_way_wr_t [NUM_WAYS-1:0]  way_wr;   // Line writes back to the ways
    l2_cache_pkg::l2_rsp_t                    rsp;

    // Address split and size decode
    l2_req_decode i_req_decode (
        .acc_valid_i (acc_valid_i),
        .wr_en_i     (wr_en_i),
        .addr_i      (addr_i),
        .wr_data_i   (wr_data_i),
        .l3_data_i   (l3_data_i),
        .byte_en_i   (byte_en_i),
        .req_o       (req),
        .req_err_o   (req_err)
    );

    // All ways look up the same set in parallel
    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        l2_way i_way (
            .clk     (clk),
            .rst_n_i (rst_n_i),
            .req_i   (req),
            .wr_i    (way_wr[w]),
            .rd_o    (way_rd[w])
        );
    end

    // Hit or victim choice, ages and response
    l2_way_select #(
        .NUM_WAYS (NUM_WAYS)
    ) i_way_select (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .req_i     (req),
        .req_err_i (req_err),
        .rd_i      (way_rd),
        .wr_o      (way_wr),
        .rsp_o     (rsp)
    );

    assign rsp_valid_o = rsp.valid;
    assign rsp_hit_o   = rsp.hit;
    assign rsp_err_o   = rsp.err;
    assign rsp_data_o  = rsp.data;

endmodule

// File: hdl/l2_req_decode.sv
`timescale 1ns/1ps

`include "l2_cache_settings.svh"

module l2_req_decode (
    input  logic                    acc_valid_i,    // Single-cycle access strobe
    input  logic                    wr_en_i,
    input  logic [`L2_ADDR_W-1:0]   addr_i,
    input  logic [`L2_DATA_W-1:0]   wr_data_i,
    input  logic [`L2_DATA_W-1:0]   l3_data_i,      // Fill word for this address
    input  logic [3:0]              byte_en_i,
    output l2_cache_pkg::l2_req_t   req_o,
    output logic                    req_err_o       // Strobe with an illegal code
);

    localparam int unsigned IDX_W = l2_cache_pkg::L2_INDEX_W;
    localparam int unsigned IDX_LO = `L2_LOW_TAG_W;             // Index sits above the low tag
    localparam int unsigned IDX_HI = IDX_LO + IDX_W - 1;

    l2_cache_pkg::l2_size_e size;
    logic                   legal;

    // Only byte, half and word are supported, all aligned to bit 0
    always_comb begin
        size  = l2_cache_pkg::SIZE_WORD;
        legal = 1'b1;
        case (byte_en_i)
            4'b0001: size = l2_cache_pkg::SIZE_BYTE;
            4'b0011: size = l2_cache_pkg::SIZE_HALF;
            4'b1111: size = l2_cache_pkg::SIZE_WORD;
            default: legal = 1'b0;      // Anything else is rejected
        endcase
    end

    // An illegal strobe never reaches the ways
    assign req_o.valid = acc_valid_i & legal;
    assign req_o.write = wr_en_i;
    assign req_o.size  = size;

    // Address split
    assign req_o.index = addr_i[IDX_HI:IDX_LO];
    // High bits above the index, then the two low bits
    assign req_o.tag   = {addr_i[`L2_ADDR_W-1:IDX_HI+1], addr_i[IDX_LO-1:0]};

    // Payload passes straight on
    assign req_o.wdata = wr_data_i;
    assign req_o.fill  = l3_data_i;

    assign req_err_o = acc_valid_i & ~legal;

endmodule

// File: hdl/l2_way.sv
`timescale 1ns/1ps

`include "l2_cache_settings.svh"

module l2_way (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  l2_cache_pkg::l2_req_t     req_i,    // Lookup address for this cycle
    input  l2_cache_pkg::l2_way_wr_t  wr_i,     // Fill or merge from the selector
    output l2_cache_pkg::l2_way_rd_t  rd_o
);

    localparam int unsigned TAG_W = l2_cache_pkg::L2_TAG_W;

    logic [`L2_NUM_SETS-1:0] valid_q;                   // One valid bit per set
    logic [TAG_W-1:0]        tag_mem  [`L2_NUM_SETS];
    logic [`L2_DATA_W-1:0]   data_mem [`L2_NUM_SETS];

    logic                    line_valid;
    logic                    tag_match;

    // Valid bits are the only state here that reset clears
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (wr_i.en) begin
            valid_q[wr_i.index] <= 1'b1;    // Every write installs a line
        end
    end

    // Tag and data arrays
    always_ff @(posedge clk) begin
        if (wr_i.en) begin
            tag_mem[wr_i.index]  <= wr_i.tag;
            data_mem[wr_i.index] <= wr_i.data;
        end
    end

    // Read of the indexed line, combinational in the access cycle
    assign line_valid = valid_q[req_i.index];
    assign tag_match  = (tag_mem[req_i.index] == req_i.tag);

    // Hit only for a legal access
    assign rd_o.hit   = req_i.valid & line_valid & tag_match;
    assign rd_o.valid = line_valid;
    assign rd_o.data  = data_mem[req_i.index];

endmodule

// File: hdl/l2_way_select.sv
`timescale 1ns/1ps

`include "l2_cache_settings.svh"

module l2_way_select #(
    parameter int NUM_WAYS = `L2_NUM_WAYS
) (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  l2_cache_pkg::l2_req_t                    req_i,
    input  logic                                     req_err_i,   // Illegal byte enable
    input  l2_cache_pkg::l2_way_rd_t [NUM_WAYS-1:0]  rd_i,
    output l2_cache_pkg::l2_way_wr_t [NUM_WAYS-1:0]  wr_o,
    output l2_cache_pkg::l2_rsp_t                    rsp_o
);

    localparam int unsigned WAY_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;
    localparam int unsigned AGE_W = l2_cache_pkg::L2_AGE_W;

    // Per-set saturating ages, 0 is most recent
    logic [NUM_WAYS-1:0][AGE_W-1:0] age_q [`L2_NUM_SETS];
    logic [NUM_WAYS-1:0][AGE_W-1:0] set_age;

    logic                  hit_any;
    logic [WAY_W-1:0]      hit_way;
    logic                  inv_any;
    logic [WAY_W-1:0]      inv_way;
    logic [WAY_W-1:0]      old_way;
    logic [AGE_W-1:0]      old_age;
    logic [WAY_W-1:0]      sel_way;
    logic [`L2_DATA_W-1:0] base_word;
    logic [`L2_DATA_W-1:0] new_word;

    logic                  rsp_valid_q;
    logic                  rsp_hit_q;
    logic                  rsp_err_q;
    logic [`L2_DATA_W-1:0] rsp_data_q;

    // Write bytes over the base word, low byte or low half or all
    function automatic logic [`L2_DATA_W-1:0] merge_word(
        input logic [`L2_DATA_W-1:0] base,
        input logic [`L2_DATA_W-1:0] wdata,
        input l2_cache_pkg::l2_size_e size
    );
        logic [`L2_DATA_W-1:0] res;
        res = base;
        case (size)
            l2_cache_pkg::SIZE_BYTE: res[7:0]  = wdata[7:0];
            l2_cache_pkg::SIZE_HALF: res[15:0] = wdata[15:0];
            default:                 res       = wdata;
        endcase
        return res;
    endfunction

    // Zero-extend read data to the access size
    function automatic logic [`L2_DATA_W-1:0] size_mask(
        input logic [`L2_DATA_W-1:0] word,
        input l2_cache_pkg::l2_size_e size
    );
        logic [`L2_DATA_W-1:0] res;
        res = '0;
        case (size)
            l2_cache_pkg::SIZE_BYTE: res[7:0]  = word[7:0];
            l2_cache_pkg::SIZE_HALF: res[15:0] = word[15:0];
            default:                 res       = word;
        endcase
        return res;
    endfunction

    assign set_age = age_q[req_i.index];

    // Way choice, all in the access cycle
    always_comb begin
        hit_any = 1'b0;
        hit_way = '0;
        inv_any = 1'b0;
        inv_way = '0;
        // Walk downwards so the lowest index wins
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (rd_i[w].hit) begin
                hit_any = 1'b1;
                hit_way = WAY_W'(w);
            end
            if (!rd_i[w].valid) begin
                inv_any = 1'b1;
                inv_way = WAY_W'(w);
            end
        end
        // Oldest way, ties go to the lower index
        old_way = '0;
        old_age = set_age[0];
        for (int w = 1; w < NUM_WAYS; w++) begin
            if (set_age[w] > old_age) begin
                old_age = set_age[w];
                old_way = WAY_W'(w);
            end
        end
        if (hit_any)      sel_way = hit_way;
        else if (inv_any) sel_way = inv_way;    // Free slot before eviction
        else              sel_way = old_way;
    end

    // Hit keeps the stored word, a miss starts from the fill word
    assign base_word = hit_any ? rd_i[hit_way].data : req_i.fill;
    assign new_word  = req_i.write ? merge_word(base_word, req_i.wdata, req_i.size) : base_word;

    // Way writes; a read hit leaves the line alone
    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            wr_o[w].en    = req_i.valid && (sel_way == WAY_W'(w)) && (!hit_any || req_i.write);
            wr_o[w].index = req_i.index;
            wr_o[w].tag   = req_i.tag;
            wr_o[w].data  = new_word;
        end
    end

    // Age update for the accessed set
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `L2_NUM_SETS; s++) begin
                age_q[s] <= '0;
            end
        end else if (req_i.valid) begin
            for (int w = 0; w < NUM_WAYS; w++) begin
                if (sel_way == WAY_W'(w)) begin
                    age_q[req_i.index][w] <= '0;
                end else if (set_age[w] != '1) begin
                    age_q[req_i.index][w] <= set_age[w] + 1'b1;   // Saturate at max
                end
            end
        end
    end

    // Response flags, one cycle after the strobe
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
            rsp_hit_q   <= 1'b0;
            rsp_err_q   <= 1'b0;
        end else begin
            rsp_valid_q <= req_i.valid | req_err_i;
            rsp_hit_q   <= req_i.valid & hit_any;
            rsp_err_q   <= req_err_i;
        end
    end

    // Response data, zero for an illegal access
    always_ff @(posedge clk) begin
        rsp_data_q <= req_i.valid ? size_mask(new_word, req_i.size) : '0;
    end

    assign rsp_o.valid = rsp_valid_q;
    assign rsp_o.hit   = rsp_hit_q;
    assign rsp_o.err   = rsp_err_q;
    assign rsp_o.data  = rsp_data_q;

endmodule

// File: l2_cache_top.f
+incdir+hdl
hdl/l2_cache_pkg.sv
hdl/l2_req_decode.sv
hdl/l2_way.sv
hdl/l2_way_select.sv
hdl/l2_cache_top.sv
verif/tb_clk_gen.sv
verif/l2_cache_properties.sv
verif/tb_l2_cache_top.sv

// File: verif/l2_cache_properties.sv
`timescale 1ns/1ps

`include "l2_cache_settings.svh"

module l2_cache_properties #(
    parameter int NUM_WAYS = `L2_NUM_WAYS
) (
    input logic                                    clk,
    input logic                                    rst_n_i,
    input logic                                    acc_valid_i,
    input logic                                    rsp_valid_i,
    input logic                                    rsp_hit_i,
    input logic                                    rsp_err_i,
    input l2_cache_pkg::l2_way_rd_t [NUM_WAYS-1:0] way_rd_i     // Per-way lookup results
);

    logic [NUM_WAYS-1:0] hit_vec;

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit_vec[w] = way_rd_i[w].hit;
        end
    end

    // Every strobe is answered one cycle later
    a_rsp_after_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        acc_valid_i |=> rsp_valid_i)
        else $error("No response one cycle after an access strobe");

    a_no_rsp_without_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
        !acc_valid_i |=> !rsp_valid_i)
        else $error("Response without an access strobe one cycle before");

    // A rejected access never reports a hit
    a_err_not_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        rsp_err_i |-> !rsp_hit_i)
        else $error("Error response also flags a hit");

    a_one_hit: assert property (@(posedge clk) disable iff (!rst_n_i)
        $onehot0(hit_vec))
        else $error("More than one way hits in the same cycle");

    // Async reset clears the response flags
    a_idle_in_reset: assert property (@(posedge clk)
        !rst_n_i |-> !(rsp_valid_i | rsp_hit_i | rsp_err_i))
        else $error("Response flags active during reset");

endmodule

bind l2_cache_top l2_cache_properties #(
    .NUM_WAYS (NUM_WAYS)
) i_l2_cache_properties (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .acc_valid_i (acc_valid_i),
    .rsp_valid_i (rsp_valid_o),
    .rsp_hit_i   (rsp_hit_o),
    .rsp_err_i   (rsp_err_o),
    .way_rd_i    (way_rd)
);

// File: verif/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int RESET_CYCLES = 8
) (
    input  logic restart_i,     // Rising edge requests another reset
    output logic clk,
    output logic rst_n_o
);

    initial clk = 1'b0;
    always #5 clk = ~clk;       // 10 ns period

    // Reset at time zero and again on every restart request
    always begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n_o = 1'b1;         // Release away from the active edge
        @(posedge restart_i);
    end

endmodule

// File: verif/tb_l2_cache_top.sv
`timescale 1ns/1ps

`include "l2_cache_settings.svh"

module tb_l2_cache_top;

    localparam int WAYS        = `L2_NUM_WAYS;
    localparam int SETS        = `L2_NUM_SETS;
    localparam int RSP_TIMEOUT = 4;         // Cycles allowed for one response
    localparam int RST_TIMEOUT = 50;
    localparam int WATCHDOG    = 20000;

    logic        clk;
    logic        rst_n;
    logic        restart;
    logic        acc_valid;
    logic        wr_en;
    logic [31:0] addr;
    logic [31:0] wr_data;
    logic [3:0]  byte_en;
    logic [31:0] l3_data;
    logic        rsp_valid;
    logic        rsp_hit;
    logic        rsp_err;
    logic [31:0] rsp_data;

    // Reference model of the cache state
    logic        m_valid [WAYS][SETS];
    logic [23:0] m_tag   [WAYS][SETS];
    logic [31:0] m_data  [WAYS][SETS];
    int          m_age   [WAYS][SETS];      // 0 is most recent

    logic [31:0] rng_state;

    tb_clk_gen i_clk_gen (
        .restart_i (restart),
        .clk       (clk),
        .rst_n_o   (rst_n)
    );

    l2_cache_top i_l2_cache_top (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .acc_valid_i (acc_valid),
        .wr_en_i     (wr_en),
        .addr_i      (addr),
        .wr_data_i   (wr_data),
        .byte_en_i   (byte_en),
        .l3_data_i   (l3_data),
        .rsp_valid_o (rsp_valid),
        .rsp_hit_o   (rsp_hit),
        .rsp_err_o   (rsp_err),
        .rsp_data_o  (rsp_data)
    );

    // Xorshift32 step
    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Bytes covered by a byte enable code
    function automatic logic [31:0] be_mask(input logic [3:0] be);
        return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
    endfunction

    function automatic logic [31:0] make_addr(input logic [21:0] hi, input logic [7:0] idx,
                                              input logic [1:0] lo);
        return {hi, idx, lo};
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else report_failure($sformatf("Fail %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic model_reset();
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < SETS; s++) begin
                m_valid[w][s] = 1'b0;
                m_age[w][s]   = 0;
            end
        end
    endtask

    // Predicts one response and applies the state change
    task automatic model_access(input logic wr, input logic [31:0] a, input logic [31:0] wdata,
                                input logic [3:0] be, input logic [31:0] l3,
                                output logic exp_hit, output logic exp_err,
                                output logic [31:0] exp_data);
        logic [7:0]  idx;
        logic [23:0] tag;
        logic [31:0] mask;
        logic [31:0] word;
        int          way;
        idx      = a[9:2];
        tag      = {a[31:10], a[1:0]};      // Low address bits belong to the tag
        mask     = be_mask(be);
        exp_err  = !(be == 4'b0001 || be == 4'b0011 || be == 4'b1111);
        exp_hit  = 1'b0;
        exp_data = '0;
        if (exp_err) return;                // Rejected so nothing changes
        way = -1;
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (m_valid[w][idx] && m_tag[w][idx] == tag) way = w;
        end
        exp_hit = (way >= 0);
        if (!exp_hit) begin
            for (int w = WAYS - 1; w >= 0; w--) begin
                if (!m_valid[w][idx]) way = w;      // Lowest free way
            end
        end
        if (way < 0) begin
            way = 0;
            for (int w = 1; w < WAYS; w++) begin
                if (m_age[w][idx] > m_age[way][idx]) way = w;   // Oldest with low index on a tie
            end
        end
        word = exp_hit ? m_data[way][idx] : l3;
        if (wr) word = (word & ~mask) | (wdata & mask);
        m_valid[way][idx] = 1'b1;
        m_tag[way][idx]   = tag;
        m_data[way][idx]  = word;
        for (int w = 0; w < WAYS; w++) begin
            if (w == way) m_age[w][idx] = 0;
            else if (m_age[w][idx] < WAYS - 1) m_age[w][idx]++;
        end
        exp_data = word & mask;             // Zero-extended read data
    endtask

    // One access on the falling edge with the response checked a cycle later
    task automatic access(input logic wr, input logic [31:0] a, input logic [31:0] wdata,
                          input logic [3:0] be, input logic [31:0] l3);
        logic        exp_hit;
        logic        exp_err;
        logic [31:0] exp_data;
        int          cycles;
        acc_valid = 1'b1;
        wr_en     = wr;
        addr      = a;
        wr_data   = wdata;
        byte_en   = be;
        l3_data   = l3;
        model_access(wr, a, wdata, be, l3, exp_hit, exp_err, exp_data);
        cycles = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (rsp_valid !== 1'b1 && cycles < RSP_TIMEOUT);
        if (rsp_valid !== 1'b1)
            report_failure($sformatf("No response within %0d cycles", RSP_TIMEOUT));
        assert (cycles == 1)
        else report_failure($sformatf("Response came %0d cycles after the strobe", cycles));
        check_value("rsp_err_o", exp_err, rsp_err);
        check_value("rsp_hit_o", exp_hit, rsp_hit);
        check_value("rsp_data_o", exp_data, rsp_data);
    endtask

    task automatic idle();
        acc_valid = 1'b0;
        @(negedge clk);
        check_value("rsp_valid_o", 32'h0, rsp_valid);
    endtask

    task automatic check_idle();
        check_value("rsp_valid_o", 32'h0, rsp_valid);
        check_value("rsp_hit_o", 32'h0, rsp_hit);
        check_value("rsp_err_o", 32'h0, rsp_err);
    endtask

    task automatic wait_reset(input logic level);
        int cycles;
        cycles = 0;
        while (rst_n !== level && cycles < RST_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (rst_n !== level)
            report_failure($sformatf("Reset did not reach %0b within %0d cycles", level,
                                     RST_TIMEOUT));
    endtask

    task automatic apply_reset();
        acc_valid = 1'b0;
        restart   = 1'b1;
        @(negedge clk);
        restart   = 1'b0;
        wait_reset(1'b0);
        wait_reset(1'b1);
        @(negedge clk);
        model_reset();                      // Valid bits and ages cleared
        check_idle();
    endtask

    initial begin
        repeat (WATCHDOG) @(posedge clk);
        report_failure("Simulation ran past its cycle limit");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] wd;
        logic [31:0] fw;
        logic [3:0]  be;
        logic [3:0]  bad_be [5];
        logic [21:0] hi_tab [4];
        logic [7:0]  set_tab [4];
        rng_state = 32'hcea8_1565;
        restart   = 1'b0;
        acc_valid = 1'b0;
        wr_en     = 1'b0;
        addr      = '0;
        wr_data   = '0;
        byte_en   = '0;
        l3_data   = '0;
        bad_be    = '{4'b0101, 4'b0010, 4'b1000, 4'b0000, 4'b0111};
        hi_tab    = '{22'h000001, 22'h2aaaaa, 22'h155555, 22'h3fffff};
        set_tab   = '{8'h00, 8'h01, 8'h80, 8'hff};
        model_reset();
        wait_reset(1'b1);
        @(negedge clk);
        check_idle();

        // Cold word miss followed by byte and half hits
        access(1'b0, make_addr(22'h012345, 8'h10, 2'b00), '0, 4'b1111, 32'h8bad_f00d);
        access(1'b0, make_addr(22'h012345, 8'h10, 2'b00), '0, 4'b0001, 32'hdead_beef);
        access(1'b0, make_addr(22'h012345, 8'h10, 2'b00), '0, 4'b0011, 32'hdead_beef);
        idle();

        // Merges on write hits and then write misses on top of the fill word
        access(1'b0, make_addr(22'h00abcd, 8'h20, 2'b01), '0, 4'b1111, 32'h1122_3344);
        access(1'b1, make_addr(22'h00abcd, 8'h20, 2'b01), 32'haaaa_bbcc, 4'b0001, '0);
        access(1'b1, make_addr(22'h00abcd, 8'h20, 2'b01), 32'hdddd_eeff, 4'b0011, '0);
        access(1'b0, make_addr(22'h00abcd, 8'h20, 2'b01), '0, 4'b1111, '0);
        access(1'b1, make_addr(22'h0c0ffe, 8'h21, 2'b00), 32'h5555_66aa, 4'b0001, 32'h9988_7766);
        access(1'b1, make_addr(22'h0c0ffe, 8'h22, 2'b10), 32'h0bad_cafe, 4'b0011, 32'h1357_9bdf);
        access(1'b0, make_addr(22'h0c0ffe, 8'h21, 2'b00), '0, 4'b1111, '0);
        idle();

        // Four fills in one set and a re-touch of the first before the evictions
        for (int k = 0; k < 4; k++) begin
            access(1'b0, make_addr(22'h000100 + k, 8'h5a, 2'b00), '0, 4'b1111, 32'h5a00_0000 + k);
        end
        access(1'b0, make_addr(22'h000100, 8'h5a, 2'b00), '0, 4'b1111, '0);
        access(1'b0, make_addr(22'h000104, 8'h5a, 2'b00), '0, 4'b1111, 32'h5a00_0004);
        access(1'b0, make_addr(22'h000101, 8'h5a, 2'b00), '0, 4'b1111, 32'h5a00_0011);
        access(1'b0, make_addr(22'h000100, 8'h5a, 2'b00), '0, 4'b0011, '0);
        access(1'b0, make_addr(22'h000103, 8'h5a, 2'b00), '0, 4'b1111, '0);
        idle();

        // Illegal codes and a miss whose victim depends on the untouched ages
        for (int k = 0; k < 5; k++) begin
            access(1'b1, make_addr(22'h000103, 8'h5a, 2'b00), 32'hffff_ffff, bad_be[k], '0);
        end
        access(1'b0, make_addr(22'h000103, 8'h5a, 2'b00), '0, 4'b1111, '0);
        access(1'b0, make_addr(22'h000109, 8'h5a, 2'b00), '0, 4'b1111, 32'h5a00_0009);
        // Shows which way the miss above took
        access(1'b0, make_addr(22'h000100, 8'h5a, 2'b00), '0, 4'b1111, 32'h5a00_0010);
        idle();

        // Earlier lines miss again after a mid-test reset
        apply_reset();
        access(1'b0, make_addr(22'h012345, 8'h10, 2'b00), '0, 4'b1111, 32'h0101_0101);
        access(1'b0, make_addr(22'h00abcd, 8'h20, 2'b01), '0, 4'b1111, 32'h0202_0202);
        access(1'b0, make_addr(22'h000100, 8'h5a, 2'b00), '0, 4'b1111, 32'h0303_0303);
        idle();

        // Random stream over four sets and eight tags
        for (int n = 0; n < 400; n++) begin
            r  = next_rand();
            wd = next_rand();
            fw = next_rand();
            case (r[7:5])
                3'd0, 3'd1, 3'd2: be = 4'b0001;
                3'd3, 3'd4:       be = 4'b0011;
                3'd5, 3'd6:       be = 4'b1111;
                default:          be = {r[9], 2'b10, r[8]};     // Always illegal
            endcase
            access(r[12], make_addr(hi_tab[r[4:3]], set_tab[r[1:0]], {2{r[2]}}), wd, be, fw);
            if (r[15:13] == 3'd0) idle();   // Mostly back to back
        end
        idle();

        $display(">>> PASS");
        $finish;
    end

endmodule
